//--- logic/issue_pkg.sv
////////////////////
// issue stage package
// widths, opcodes, enums and the packets that leave the issue stage
////////////////////

package issue_pkg;

    // datapath and tag widths
    localparam int data_w     = 32;
    localparam int rob_tag_w  = 4;
    localparam int num_rs     = 4;
    localparam int reg_addr_w = 5;

    // kept opcodes
    localparam logic [6:0] opc_bubble = 7'b0000000;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;

    // funct7 groups for R-type
    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;
    localparam logic [6:0] f7_mext = 7'b0000001;

    // ROB instruction kinds
    localparam logic [1:0] itype_store = 2'b01;
    localparam logic [1:0] itype_reg   = 2'b10;
    localparam logic [1:0] itype_load  = 2'b11;

    localparam logic [7:0] mcause_illegal = 8'd2;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_xor  = 4'd2,
        alu_or   = 4'd3,
        alu_and  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9,
        alu_mul  = 4'd10,
        alu_mulh = 4'd11,
        alu_div  = 4'd12,
        alu_remu = 4'd13
    } alu_op_t;

    // illegal opcodes are flagged separately in decode_t
    typedef enum logic [1:0] {
        cls_bubble = 2'd0,
        cls_alu    = 2'd1,
        cls_load   = 2'd2,
        cls_store  = 2'd3
    } instr_class_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instruction;
    } pipe_in_t;

    typedef struct packed {
        logic [rob_tag_w-1:0] tag;
        logic [data_w-1:0]    result;
        logic                 load_step1;
    } cdb_t;

    // nonzero tag means value still pending
    typedef struct packed {
        logic [data_w-1:0]    value;
        logic [rob_tag_w-1:0] tag;
    } operand_t;

    typedef struct packed {
        instr_class_t          cls;
        logic                  illegal;
        alu_op_t               alu_op;
        logic                  use_imm;
        logic [data_w-1:0]     imm;
        logic                  use_pc;
        logic                  zero_j;
        logic                  writes_rd;
        logic [reg_addr_w-1:0] rd;
        logic [2:0]            xfer_size;
        logic                  is_signed;
    } decode_t;

    typedef struct packed {
        logic                 busy;
        logic [rob_tag_w-1:0] rob_tag;
        alu_op_t              alu_op;
        logic                 load;
        operand_t             j;
        operand_t             k;
    } rs_entry_t;

    typedef struct packed {
        logic [rob_tag_w-1:0]  rob_tag;
        logic [31:0]           pc;
        logic [reg_addr_w-1:0] reg_dest;
        logic [1:0]            itype;
        logic                  exception;
        logic [7:0]            mcause;
        logic                  ready;
    } rob_entry_t;

    typedef struct packed {
        logic                 load;
        logic                 store;
        logic [rob_tag_w-1:0] rob_tag;
        logic [2:0]           xfer_size;
        logic                 is_signed;
        operand_t             store_data;
    } lsq_entry_t;

    typedef struct packed {
        logic                  write;
        logic [reg_addr_w-1:0] rd;
        logic [rob_tag_w-1:0]  rob_tag;
    } regstat_wr_t;

endpackage

//--- logic/issue_hold.sv
////////////////////
// issue hold
// latches a stalled instruction and replays it until it issues
////////////////////
`timescale 1ns/1ns

module issue_hold import issue_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pipe_in_t pipe_in,
    input  logic     stall,
    output pipe_in_t cur_instr,
    output logic     pipe_stall
);

    typedef enum logic [0:0] {
        st_empty = 1'b0,
        st_hold  = 1'b1
    } hold_state_t;

    hold_state_t state;
    hold_state_t state_next;
    pipe_in_t    hold_reg;

    always_comb begin
        state_next = state;
        case (state)
            st_empty: if (stall) state_next = st_hold;
            st_hold:  if (!stall) state_next = st_empty;
            default:  state_next = st_empty;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_empty;
            hold_reg <= '0;
        end else begin
            state <= state_next;
            // grab the live instruction only on the way into hold
            if (state == st_empty && state_next == st_hold) begin
                hold_reg <= pipe_in;
            end
        end
    end

    assign cur_instr  = (state == st_hold) ? hold_reg : pipe_in;
    assign pipe_stall = (state == st_hold);

endmodule

//--- logic/operand_resolve.sv
////////////////////
// operand resolve
// picks a source value from CDB, register file or ROB
////////////////////
`timescale 1ns/1ns

module operand_resolve import issue_pkg::*; (
    input  logic [rob_tag_w-1:0] tag,
    input  logic                 reg_busy,
    input  logic [data_w-1:0]    reg_data,
    input  logic                 rob_ready,
    input  logic [data_w-1:0]    rob_data,
    input  cdb_t                 cdb,
    output operand_t             opnd
);

    logic cdb_hit;

    // first half of a load is only an address, not a result
    assign cdb_hit = (cdb.tag == tag) && (cdb.tag != '0) && !cdb.load_step1;

    always_comb begin
        opnd.tag = '0;
        if (cdb_hit) begin
            opnd.value = cdb.result;
        end else if (!reg_busy) begin
            opnd.value = reg_data;
        end else if (rob_ready) begin
            opnd.value = rob_data;
        end else begin
            // still waiting on the producer
            opnd.value = '0;
            opnd.tag   = tag;
        end
    end

endmodule

//--- logic/instr_decode.sv
////////////////////
// instruction decode
// class, ALU op, immediate and destination write for one instruction
////////////////////
`timescale 1ns/1ns

module instr_decode import issue_pkg::*; (
    input  pipe_in_t instr,
    output decode_t  dec
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [data_w-1:0]     imm_i;
    logic [data_w-1:0]     imm_s;
    logic [data_w-1:0]     imm_u;
    logic [data_w-1:0]     shamt;
    logic                  is_shift;
    alu_op_t               r_op;
    alu_op_t               i_op;

    assign opcode = instr.instruction[6:0];
    assign funct3 = instr.instruction[14:12];
    assign funct7 = instr.instruction[31:25];
    assign rd     = instr.instruction[11:7];

    assign imm_i = {{20{instr.instruction[31]}}, instr.instruction[31:20]};
    assign imm_s = {{20{instr.instruction[31]}}, instr.instruction[31:25],
                    instr.instruction[11:7]};
    assign imm_u = {instr.instruction[31:12], 12'b0};
    assign shamt = {27'b0, instr.instruction[24:20]};

    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // R-type table, unknown combinations land on sltu
    always_comb begin
        case ({funct7, funct3})
            {f7_mext, 3'b000}: r_op = alu_mul;
            {f7_mext, 3'b001}: r_op = alu_mulh;
            {f7_mext, 3'b100}: r_op = alu_div;
            {f7_mext, 3'b111}: r_op = alu_remu;
            {f7_base, 3'b000}: r_op = alu_add;
            {f7_alt,  3'b000}: r_op = alu_sub;
            {f7_base, 3'b100}: r_op = alu_xor;
            {f7_base, 3'b110}: r_op = alu_or;
            {f7_base, 3'b111}: r_op = alu_and;
            {f7_base, 3'b001}: r_op = alu_sll;
            {f7_base, 3'b101}: r_op = alu_srl;
            {f7_alt,  3'b101}: r_op = alu_sra;
            {f7_base, 3'b010}: r_op = alu_slt;
            default:           r_op = alu_sltu;
        endcase
    end

    // I-type ops, bit 30 splits srai from srli
    always_comb begin
        case (funct3)
            3'b000:  i_op = alu_add;
            3'b100:  i_op = alu_xor;
            3'b110:  i_op = alu_or;
            3'b111:  i_op = alu_and;
            3'b001:  i_op = alu_sll;
            3'b101:  i_op = instr.instruction[30] ? alu_sra : alu_srl;
            3'b010:  i_op = alu_slt;
            default: i_op = alu_sltu;
        endcase
    end

    always_comb begin
        dec        = '0;
        dec.cls    = cls_bubble;
        dec.alu_op = alu_add;
        dec.rd     = rd;

        case (opcode)
            opc_bubble: begin
                dec.cls = cls_bubble;
            end
            opc_op: begin
                dec.cls    = cls_alu;
                dec.alu_op = r_op;
            end
            opc_op_imm: begin
                dec.cls     = cls_alu;
                dec.alu_op  = i_op;
                dec.use_imm = 1'b1;
                dec.imm     = is_shift ? shamt : imm_i;
            end
            opc_lui: begin
                dec.cls     = cls_alu;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.zero_j  = 1'b1;
            end
            opc_auipc: begin
                dec.cls     = cls_alu;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.use_pc  = 1'b1;
            end
            opc_load: begin
                dec.cls     = cls_load;
                dec.use_imm = 1'b1;
                dec.imm     = imm_i;
            end
            opc_store: begin
                dec.cls     = cls_store;
                dec.use_imm = 1'b1;
                dec.imm     = imm_s;
            end
            default: begin
                // goes to the ROB only, as an exception
                dec.cls     = cls_alu;
                dec.illegal = 1'b1;
            end
        endcase

        // alu result into x0 has no effect
        if (dec.cls == cls_alu && !dec.illegal && rd == '0) begin
            dec.cls = cls_bubble;
        end

        dec.writes_rd = (rd != '0) &&
                        ((dec.cls == cls_alu && !dec.illegal) || dec.cls == cls_load);

        // one-hot byte count, sign only matters for loads
        if (dec.cls == cls_load || dec.cls == cls_store) begin
            case (funct3)
                3'b000: {dec.xfer_size, dec.is_signed} = {3'b001, 1'b1};
                3'b001: {dec.xfer_size, dec.is_signed} = {3'b010, 1'b1};
                3'b010: {dec.xfer_size, dec.is_signed} = {3'b100, 1'b1};
                3'b100: {dec.xfer_size, dec.is_signed} = {3'b001, 1'b0};
                3'b101: {dec.xfer_size, dec.is_signed} = {3'b010, 1'b0};
                default: {dec.xfer_size, dec.is_signed} = {3'b100, 1'b0};
            endcase
        end
    end

endmodule

//--- logic/dispatch_pack.sv
////////////////////
// dispatch pack
// station choice, stall, and the RS, ROB, LSQ and regstat packets
////////////////////
`timescale 1ns/1ns

module dispatch_pack import issue_pkg::*; (
    input  pipe_in_t             instr,
    input  decode_t              dec,
    input  operand_t             opnd_j,
    input  operand_t             opnd_k,
    input  logic [num_rs-1:0]    rs_busy,
    input  logic [rob_tag_w-1:0] rob_free_tag,
    input  logic                 rob_full,
    input  logic                 lsq_full,
    output logic                 stall,
    output logic [1:0]           rs_sel,
    output rs_entry_t            rs_entry,
    output rob_entry_t           rob_entry,
    output lsq_entry_t           lsq_entry,
    output regstat_wr_t          regstat_wr
);

    logic                 rs_avail;
    logic                 is_bubble;
    logic                 is_load;
    logic                 is_store;
    logic [rob_tag_w-1:0] issue_tag;
    operand_t             j_final;
    operand_t             k_final;

    // lowest free station wins, scanned from the top down
    always_comb begin
        rs_sel   = '0;
        rs_avail = 1'b0;
        for (int i = num_rs - 1; i >= 0; i--) begin
            if (!rs_busy[i]) begin
                rs_sel   = 2'(i);
                rs_avail = 1'b1;
            end
        end
    end

    assign is_bubble = (dec.cls == cls_bubble);
    assign is_load   = (dec.cls == cls_load);
    assign is_store  = (dec.cls == cls_store);

    assign stall = !is_bubble &&
                   (!rs_avail || rob_full || ((is_load || is_store) && lsq_full));

    assign issue_tag = (stall || is_bubble) ? '0 : rob_free_tag;

    // immediate, pc and lui zero replace the register operands
    always_comb begin
        j_final = opnd_j;
        k_final = opnd_k;
        if (dec.zero_j) begin
            j_final = '0;
        end else if (dec.use_pc) begin
            j_final.value = instr.pc;
            j_final.tag   = '0;
        end
        if (dec.use_imm) begin
            k_final.value = dec.imm;
            k_final.tag   = '0;
        end
    end

    always_comb begin
        rs_entry.busy    = !stall && !is_bubble && !dec.illegal;
        rs_entry.rob_tag = issue_tag;
        rs_entry.alu_op  = dec.alu_op;
        rs_entry.load    = is_load || is_store;
        rs_entry.j       = j_final;
        rs_entry.k       = k_final;
    end

    always_comb begin
        rob_entry.rob_tag   = issue_tag;
        rob_entry.pc        = instr.pc;
        rob_entry.reg_dest  = dec.writes_rd ? dec.rd : '0;
        rob_entry.exception = dec.illegal;
        rob_entry.mcause    = dec.illegal ? mcause_illegal : 8'd0;
        rob_entry.ready     = 1'b0;
        if (is_store) begin
            rob_entry.itype = itype_store;
        end else if (is_load) begin
            rob_entry.itype = itype_load;
        end else begin
            rob_entry.itype = itype_reg;
        end
    end

    // store data is rs2 before the offset replaced it
    always_comb begin
        lsq_entry.load       = is_load && !stall;
        lsq_entry.store      = is_store && !stall;
        lsq_entry.rob_tag    = issue_tag;
        lsq_entry.xfer_size  = dec.xfer_size;
        lsq_entry.is_signed  = dec.is_signed;
        lsq_entry.store_data = is_store ? opnd_k : '0;
    end

    always_comb begin
        regstat_wr.write   = dec.writes_rd && !stall;
        regstat_wr.rd      = dec.rd;
        regstat_wr.rob_tag = issue_tag;
    end

endmodule

//--- logic/issue_top.sv
////////////////////
// issue stage top
// hold, decode, operand resolve and dispatch
////////////////////
`timescale 1ns/1ns

module issue_top import issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  pipe_in_t              pipe_in,
    input  logic [data_w-1:0]     rs1_data,
    input  logic [data_w-1:0]     rs2_data,
    input  logic [rob_tag_w-1:0]  q_j,
    input  logic [rob_tag_w-1:0]  q_k,
    input  logic                  rs1_busy,
    input  logic                  rs2_busy,
    input  logic                  rs1_rob_ready,
    input  logic                  rs2_rob_ready,
    input  logic [data_w-1:0]     rs1_rob_data,
    input  logic [data_w-1:0]     rs2_rob_data,
    input  logic [rob_tag_w-1:0]  rob_free_tag,
    input  logic                  rob_full,
    input  logic                  lsq_full,
    input  logic [num_rs-1:0]     rs_busy,
    input  cdb_t                  cdb,
    output logic                  pipe_stall,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    output logic [1:0]            rs_sel,
    output rs_entry_t             rs_entry,
    output rob_entry_t            rob_entry,
    output lsq_entry_t            lsq_entry,
    output regstat_wr_t           regstat_wr
);

    pipe_in_t cur_instr;
    decode_t  dec;
    operand_t opnd_j;
    operand_t opnd_k;
    logic     stall;

    issue_hold u_hold (
        .clk        (clk),
        .reset      (reset),
        .pipe_in    (pipe_in),
        .stall      (stall),
        .cur_instr  (cur_instr),
        .pipe_stall (pipe_stall)
    );

    // register file and regstat lookups use the current instruction
    assign rs1_addr = cur_instr.instruction[19:15];
    assign rs2_addr = cur_instr.instruction[24:20];

    instr_decode u_decode (
        .instr (cur_instr),
        .dec   (dec)
    );

    operand_resolve u_opnd_j (
        .tag       (q_j),
        .reg_busy  (rs1_busy),
        .reg_data  (rs1_data),
        .rob_ready (rs1_rob_ready),
        .rob_data  (rs1_rob_data),
        .cdb       (cdb),
        .opnd      (opnd_j)
    );

    operand_resolve u_opnd_k (
        .tag       (q_k),
        .reg_busy  (rs2_busy),
        .reg_data  (rs2_data),
        .rob_ready (rs2_rob_ready),
        .rob_data  (rs2_rob_data),
        .cdb       (cdb),
        .opnd      (opnd_k)
    );

    dispatch_pack u_dispatch (
        .instr        (cur_instr),
        .dec          (dec),
        .opnd_j       (opnd_j),
        .opnd_k       (opnd_k),
        .rs_busy      (rs_busy),
        .rob_free_tag (rob_free_tag),
        .rob_full     (rob_full),
        .lsq_full     (lsq_full),
        .stall        (stall),
        .rs_sel       (rs_sel),
        .rs_entry     (rs_entry),
        .rob_entry    (rob_entry),
        .lsq_entry    (lsq_entry),
        .regstat_wr   (regstat_wr)
    );

endmodule

//--- verification/issue_tb.sv
////////////////////
// issue stage testbench
// seeded random instructions and side inputs checked against a model
////////////////////
`timescale 1ns/1ns

module issue_tb import issue_pkg::*; ();

    logic                  clk;
    logic                  reset;
    pipe_in_t              pipe_in;
    logic [data_w-1:0]     rs1_data;
    logic [data_w-1:0]     rs2_data;
    logic [rob_tag_w-1:0]  q_j;
    logic [rob_tag_w-1:0]  q_k;
    logic                  rs1_busy;
    logic                  rs2_busy;
    logic                  rs1_rob_ready;
    logic                  rs2_rob_ready;
    logic [data_w-1:0]     rs1_rob_data;
    logic [data_w-1:0]     rs2_rob_data;
    logic [rob_tag_w-1:0]  rob_free_tag;
    logic                  rob_full;
    logic                  lsq_full;
    logic [num_rs-1:0]     rs_busy;
    cdb_t                  cdb;
    logic                  pipe_stall;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [1:0]            rs_sel;
    rs_entry_t             rs_entry;
    rob_entry_t            rob_entry;
    lsq_entry_t            lsq_entry;
    regstat_wr_t           regstat_wr;

    // model of the hold register
    logic     model_hold;
    pipe_in_t model_held;

    issue_top u_dut (
        .clk           (clk),
        .reset         (reset),
        .pipe_in       (pipe_in),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .q_j           (q_j),
        .q_k           (q_k),
        .rs1_busy      (rs1_busy),
        .rs2_busy      (rs2_busy),
        .rs1_rob_ready (rs1_rob_ready),
        .rs2_rob_ready (rs2_rob_ready),
        .rs1_rob_data  (rs1_rob_data),
        .rs2_rob_data  (rs2_rob_data),
        .rob_free_tag  (rob_free_tag),
        .rob_full      (rob_full),
        .lsq_full      (lsq_full),
        .rs_busy       (rs_busy),
        .cdb           (cdb),
        .pipe_stall    (pipe_stall),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs_sel        (rs_sel),
        .rs_entry      (rs_entry),
        .rob_entry     (rob_entry),
        .lsq_entry     (lsq_entry),
        .regstat_wr    (regstat_wr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic is_kept(input logic [6:0] opc);
        return opc inside {opc_op, opc_op_imm, opc_load, opc_store, opc_lui, opc_auipc};
    endfunction

    function automatic logic [31:0] make_instr();
        logic [31:0] ins;
        int unsigned kind;
        int unsigned idx;
        ins  = $urandom;
        kind = $urandom_range(0, 15);
        idx  = $urandom_range(0, 4);
        // x0 destinations show up often enough to matter
        if ($urandom_range(0, 7) == 0) begin
            ins[11:7] = '0;
        end
        case (kind)
            0:       ins = '0;
            1:       ins[6:0] = opc_bubble;
            2:       ins[6:0] = opc_op;
            3, 4: begin
                ins[6:0]   = opc_op;
                ins[31:25] = $urandom_range(0, 1) ? f7_base : f7_alt;
            end
            5: begin
                ins[6:0]   = opc_op;
                ins[31:25] = f7_mext;
            end
            6, 7, 8: ins[6:0] = opc_op_imm;
            9:       ins[6:0] = opc_lui;
            10:      ins[6:0] = opc_auipc;
            11, 12: begin
                // lb lh lw lbu lhu
                ins[6:0]   = opc_load;
                ins[14:12] = (idx < 3) ? 3'(idx) : 3'(idx + 1);
            end
            13, 14: begin
                ins[6:0]   = opc_store;
                ins[14:12] = 3'($urandom_range(0, 2));
            end
            default: begin
                if (is_kept(ins[6:0]) || ins[6:0] == opc_bubble) begin
                    ins[6:0] = 7'b1110011;
                end
            end
        endcase
        return ins;
    endfunction

    function automatic logic [3:0] alu_op_of(input logic [31:0] ins);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = ins[14:12];
        f7 = ins[31:25];
        if (ins[6:0] == opc_op) begin
            if (f7 == f7_mext) begin
                case (f3)
                    3'd0:    return alu_mul;
                    3'd1:    return alu_mulh;
                    3'd4:    return alu_div;
                    3'd7:    return alu_remu;
                    default: return alu_sltu;
                endcase
            end else if (f7 == f7_alt) begin
                if (f3 == 3'd0) return alu_sub;
                if (f3 == 3'd5) return alu_sra;
                return alu_sltu;
            end else if (f7 == f7_base) begin
                case (f3)
                    3'd0:    return alu_add;
                    3'd1:    return alu_sll;
                    3'd2:    return alu_slt;
                    3'd4:    return alu_xor;
                    3'd5:    return alu_srl;
                    3'd6:    return alu_or;
                    3'd7:    return alu_and;
                    default: return alu_sltu;
                endcase
            end
            return alu_sltu;
        end
        if (ins[6:0] == opc_op_imm) begin
            case (f3)
                3'd0:    return alu_add;
                3'd1:    return alu_sll;
                3'd2:    return alu_slt;
                3'd3:    return alu_sltu;
                3'd4:    return alu_xor;
                3'd5:    return ins[30] ? alu_sra : alu_srl;
                3'd6:    return alu_or;
                default: return alu_and;
            endcase
        end
        // lui, auipc and address generation all add
        return alu_add;
    endfunction

    function automatic logic [31:0] imm_of(input logic [31:0] ins);
        logic [2:0] f3;
        f3 = ins[14:12];
        case (ins[6:0])
            opc_op_imm: begin
                if (f3 == 3'd1 || f3 == 3'd5) return {27'b0, ins[24:20]};
                return {{20{ins[31]}}, ins[31:20]};
            end
            opc_lui, opc_auipc: return {ins[31:12], 12'b0};
            opc_load:  return {{20{ins[31]}}, ins[31:20]};
            opc_store: return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            default:   return '0;
        endcase
    endfunction

    // cdb first, then register file, then rob, else wait on the tag
    function automatic operand_t resolve_operand(input logic [3:0] tag, input logic busy,
                                                 input logic [31:0] data, input logic ready,
                                                 input logic [31:0] rdata);
        if (cdb.tag == tag && tag != '0 && !cdb.load_step1) return {cdb.result, 4'h0};
        if (!busy) return {data, 4'h0};
        if (ready) return {rdata, 4'h0};
        return {32'h0, tag};
    endfunction

    function automatic logic [1:0] lowest_free(input logic [num_rs-1:0] busy);
        for (int i = 0; i < num_rs; i++) begin
            if (!busy[i]) return 2'(i);
        end
        return 2'd0;
    endfunction

    task automatic check_outputs(output logic exp_stall);
        pipe_in_t    cur;
        logic [31:0] ins;
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic        is_load;
        logic        is_store;
        logic        is_mem;
        logic        illegal;
        logic        bubble;
        logic        writes;
        logic        any_free;
        logic        issue;
        logic [3:0]  tag;
        logic [2:0]  size;
        operand_t    res_k;
        operand_t    exp_j;
        operand_t    exp_k;

        cur      = model_hold ? model_held : pipe_in;
        ins      = cur.instruction;
        opc      = ins[6:0];
        rd       = ins[11:7];
        is_load  = (opc == opc_load);
        is_store = (opc == opc_store);
        is_mem   = is_load || is_store;
        illegal  = (opc != opc_bubble) && !is_kept(opc);
        bubble   = (opc == opc_bubble) || (!illegal && !is_mem && rd == '0);
        writes   = (rd != '0) && !illegal && !is_store && (opc != opc_bubble);
        any_free = (rs_busy != '1);
        exp_stall = !bubble && (!any_free || rob_full || (is_mem && lsq_full));
        issue    = !exp_stall && !bubble;
        tag      = issue ? rob_free_tag : 4'h0;
        res_k    = resolve_operand(q_k, rs2_busy, rs2_data, rs2_rob_ready, rs2_rob_data);
        exp_j    = resolve_operand(q_j, rs1_busy, rs1_data, rs1_rob_ready, rs1_rob_data);
        exp_k    = res_k;
        if (opc == opc_lui) begin
            exp_j = '0;
        end else if (opc == opc_auipc) begin
            exp_j = {cur.pc, 4'h0};
        end
        if (opc != opc_op && !illegal && opc != opc_bubble) begin
            exp_k = {imm_of(ins), 4'h0};
        end
        case (ins[13:12])
            2'd0:    size = 3'b001;
            2'd1:    size = 3'b010;
            default: size = 3'b100;
        endcase

        check_value("pipe_stall", pipe_stall, model_hold);
        check_value("rs1_addr", rs1_addr, ins[19:15]);
        check_value("rs2_addr", rs2_addr, ins[24:20]);
        check_value("rs_entry.busy", rs_entry.busy, issue && !illegal);
        check_value("rob_entry.rob_tag", rob_entry.rob_tag, tag);
        check_value("lsq_entry.load", lsq_entry.load, is_load && !exp_stall);
        check_value("lsq_entry.store", lsq_entry.store, is_store && !exp_stall);
        check_value("regstat_wr.write", regstat_wr.write, writes && !exp_stall);
        if (any_free) begin
            check_value("rs_sel", rs_sel, lowest_free(rs_busy));
        end
        if (issue && !illegal) begin
            check_value("rs_entry.rob_tag", rs_entry.rob_tag, tag);
            check_value("rs_entry.alu_op", rs_entry.alu_op, alu_op_of(ins));
            check_value("rs_entry.load", rs_entry.load, is_mem);
            check_value("rs_entry.j", rs_entry.j, exp_j);
            check_value("rs_entry.k", rs_entry.k, exp_k);
        end
        if (issue) begin
            check_value("rob_entry.pc", rob_entry.pc, cur.pc);
            check_value("rob_entry.reg_dest", rob_entry.reg_dest, writes ? rd : 5'd0);
            check_value("rob_entry.itype", rob_entry.itype,
                        is_store ? 2'b01 : (is_load ? 2'b11 : 2'b10));
            check_value("rob_entry.exception", rob_entry.exception, illegal);
            check_value("rob_entry.mcause", rob_entry.mcause, illegal ? 8'd2 : 8'd0);
            check_value("rob_entry.ready", rob_entry.ready, 1'b0);
        end
        if (is_mem && !exp_stall) begin
            check_value("lsq_entry.rob_tag", lsq_entry.rob_tag, tag);
            check_value("lsq_entry.xfer_size", lsq_entry.xfer_size, size);
            check_value("lsq_entry.store_data", lsq_entry.store_data,
                        is_store ? res_k : operand_t'('0));
            if (is_load) begin
                check_value("lsq_entry.is_signed", lsq_entry.is_signed, !ins[14]);
            end
        end
        if (writes && !exp_stall) begin
            check_value("regstat_wr.rd", regstat_wr.rd, rd);
            check_value("regstat_wr.rob_tag", regstat_wr.rob_tag, tag);
        end
    endtask

    task automatic drive_inputs();
        logic [3:0] new_qj;
        logic [3:0] new_qk;
        int unsigned pick;
        new_qj = 4'($urandom);
        new_qk = 4'($urandom);
        pick   = $urandom_range(0, 3);
        pipe_in.pc          <= $urandom & 32'hffff_fffc;
        pipe_in.instruction <= make_instr();
        rs1_data      <= $urandom;
        rs2_data      <= $urandom;
        q_j           <= new_qj;
        q_k           <= new_qk;
        rs1_busy      <= 1'($urandom_range(0, 1));
        rs2_busy      <= 1'($urandom_range(0, 1));
        rs1_rob_ready <= 1'($urandom_range(0, 1));
        rs2_rob_ready <= 1'($urandom_range(0, 1));
        rs1_rob_data  <= $urandom;
        rs2_rob_data  <= $urandom;
        rob_free_tag  <= 4'($urandom);
        rob_full      <= ($urandom_range(0, 4) == 0);
        lsq_full      <= ($urandom_range(0, 4) == 0);
        rs_busy       <= 4'($urandom);
        // aim the broadcast at a source tag half of the time
        cdb.tag        <= (pick == 0) ? new_qj : ((pick == 1) ? new_qk : 4'($urandom));
        cdb.result     <= $urandom;
        cdb.load_step1 <= ($urandom_range(0, 3) == 0);
    endtask

    always @(negedge clk) begin
        logic exp_stall;
        if (reset) begin
            model_hold = 1'b0;
            model_held = '0;
        end else begin
            check_outputs(exp_stall);
            if (!model_hold && exp_stall) begin
                model_hold = 1'b1;
                model_held = pipe_in;
            end else if (model_hold && !exp_stall) begin
                model_hold = 1'b0;
            end
        end
    end

    // a hold that never ends means the stage is stuck
    initial begin
        int stall_run;
        stall_run = 0;
        forever begin
            @(negedge clk);
            if (!reset && pipe_stall) begin
                stall_run++;
            end else begin
                stall_run = 0;
            end
            if (stall_run > 200) begin
                $display("pipe_stall stayed high for more than 200 cycles");
                $display("Test FAILED");
                $fatal(1, "stall timeout");
            end
        end
    end

    initial begin
        int unsigned seed_dummy;
        seed_dummy = $urandom(32'h981f_4745);
        reset         = 1'b1;
        pipe_in       = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        q_j           = '0;
        q_k           = '0;
        rs1_busy      = 1'b0;
        rs2_busy      = 1'b0;
        rs1_rob_ready = 1'b0;
        rs2_rob_ready = 1'b0;
        rs1_rob_data  = '0;
        rs2_rob_data  = '0;
        rob_free_tag  = '0;
        rob_full      = 1'b0;
        lsq_full      = 1'b0;
        rs_busy       = '0;
        cdb           = '0;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
            drive_inputs();
        end
        reset <= 1'b0;
        for (int cycle = 0; cycle < 5000; cycle++) begin
            @(posedge clk);
            drive_inputs();
        end
        @(posedge clk);
        $display("Test OK");
        $finish;
    end

endmodule

//--- filelist.f
logic/issue_pkg.sv
logic/issue_hold.sv
logic/operand_resolve.sv
logic/instr_decode.sv
logic/dispatch_pack.sv
logic/issue_top.sv
verification/issue_tb.sv

//--- Bender.yml
package:
  name: issue_stage

sources:
  - files:
      - logic/issue_pkg.sv
      - logic/issue_hold.sv
      - logic/operand_resolve.sv
      - logic/instr_decode.sv
      - logic/dispatch_pack.sv
      - logic/issue_top.sv
  - target: test
    files:
      - verification/issue_tb.sv
